// File: files.f
hdl/fe_mem_geom_pkg.sv
hdl/fe_mem_if_pkg.sv
hdl/fe_itlb.sv
hdl/fe_icache.sv
hdl/fe_fault_check.sv
hdl/fe_mem_ctrl.sv
hdl/fe_mem.sv
sim/wb_rom_model.sv
sim/fe_mem_checker.sv
sim/fe_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fe_mem_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= Verification passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/fe_mem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fe_mem_tb;

   localparam int unsigned seed_init    = 32'h6466_3caf;
   localparam int          cmd_timeout  = 40;
   localparam int          resp_timeout = 300;

   localparam fe_mem_if_pkg::fe_op_e  fetch_op = fe_mem_if_pkg::op_fetch;
   localparam fe_mem_if_pkg::fe_op_e  fill_op  = fe_mem_if_pkg::op_fill;
   localparam fe_mem_if_pkg::fe_op_e  fence_op = fe_mem_if_pkg::op_fence;
   localparam fe_mem_geom_pkg::priv_t ps       = fe_mem_geom_pkg::priv_s;
   localparam fe_mem_geom_pkg::priv_t pu       = fe_mem_geom_pkg::priv_u;
   localparam logic                   on       = 1'b1;
   localparam logic                   off      = 1'b0;

   typedef struct packed {
      fe_mem_if_pkg::fe_op_e     op;
      fe_mem_geom_pkg::vaddr_t   vaddr;
      logic                      xlate;
      fe_mem_geom_pkg::priv_t    priv;
      logic                      ucm;
      fe_mem_if_pkg::tlb_entry_t fill;
      logic [3:0]                flags;  // Access, page, ITLB miss, cache miss.
      fe_mem_geom_pkg::paddr_t   paddr;
   } row_t;

   logic                    clk_i;
   logic                    reset_i;
   fe_mem_if_pkg::fe_cmd_t  cmd_i;
   logic                    cmd_v_i;
   logic                    cmd_yumi_o;
   logic                    translation_en_i;
   fe_mem_geom_pkg::priv_t  priv_i;
   logic                    uncached_mode_i;
   fe_mem_if_pkg::fe_resp_t resp_o;
   logic                    resp_v_o;
   logic                    resp_ready_i;
   fe_mem_if_pkg::wb_req_t  wb_o;
   fe_mem_if_pkg::wb_rsp_t  wb_i;
   fe_mem_if_pkg::fe_resp_t exp_resp;
   logic                    exp_v;

   row_t   rows[$];
   integer seed;
   int     errors;
   int     checked;
   int     pending;
   int     timeouts;
   logic   ok;

   fe_mem DUT (
      .clk_i, .reset_i, .cmd_i, .cmd_v_i, .cmd_yumi_o, .translation_en_i, .priv_i,
      .uncached_mode_i, .resp_o, .resp_v_o, .resp_ready_i, .wb_o, .wb_i
   );

   wb_rom_model #(.seed_init(seed_init)) u_rom (
      .clk_i, .reset_i, .wb_req_i(wb_o), .wb_rsp_o(wb_i)
   );

   fe_mem_checker u_checker (
      .clk_i, .reset_i, .resp_i(resp_o), .resp_v_i(resp_v_o), .resp_ready_i,
      .wb_cyc_i(wb_o.cyc), .exp_i(exp_resp), .exp_v_i(exp_v),
      .errors_o(errors), .checked_o(checked), .pending_o(pending)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   initial begin
      seed         = seed_init;
      resp_ready_i = 1'b0;
      forever begin
         @(negedge clk_i);
         resp_ready_i = ($random(seed) & 3) != 0;  // Withheld about one cycle in four.
      end
   end

   function automatic fe_mem_geom_pkg::instr_t rom_word(input fe_mem_geom_pkg::paddr_t a);
      return a ^ 32'hA5A5_0000;
   endfunction

   function automatic fe_mem_if_pkg::fe_resp_t expected_resp(input row_t r);
      fe_mem_if_pkg::fe_resp_t e;
      e.access_fault = r.flags[3];
      e.page_fault   = r.flags[2];
      e.itlb_miss    = r.flags[1];
      e.icache_miss  = r.flags[0];
      e.data         = (r.flags[3:1] != 3'b000) ? '0 : rom_word(r.paddr);
      return e;
   endfunction

   task automatic add_row(input fe_mem_if_pkg::fe_op_e     op,
                          input fe_mem_geom_pkg::vaddr_t   vaddr,
                          input logic                      xlate,
                          input fe_mem_geom_pkg::priv_t    priv,
                          input logic                      ucm,
                          input fe_mem_if_pkg::tlb_entry_t fill,
                          input logic [3:0]                flags,
                          input fe_mem_geom_pkg::paddr_t   paddr);
      rows.push_back('{op, vaddr, xlate, priv, ucm, fill, flags, paddr});
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////////////////////////////////////////

   task automatic build_table();
      add_row(fetch_op, 32'h0010_0048, off, ps, off, '0, 4'b0001, 32'h0010_0048);
      add_row(fetch_op, 32'h0010_004C, off, ps, off, '0, 4'b0000, 32'h0010_004C);
      add_row(fetch_op, 32'h0010_0040, off, pu, off, '0, 4'b0000, 32'h0010_0040);
      add_row(fetch_op, 32'h0000_5010, on, ps, off, '0, 4'b0010, 32'h0);
      add_row(fill_op, 32'h0000_5000, on, ps, off, {20'h00234, 1'b0, 1'b1}, 4'b0000, 32'h0);
      add_row(fetch_op, 32'h0000_5010, on, ps, off, '0, 4'b0001, 32'h0023_4010);
      add_row(fetch_op, 32'h0000_5014, on, ps, off, '0, 4'b0000, 32'h0023_4014);
      // Privilege and execute checks.
      add_row(fetch_op, 32'h0000_5018, on, pu, off, '0, 4'b0100, 32'h0);
      add_row(fill_op, 32'h0000_6000, on, ps, off, {20'h00235, 1'b1, 1'b1}, 4'b0000, 32'h0);
      add_row(fetch_op, 32'h0000_6000, on, ps, off, '0, 4'b0100, 32'h0);
      add_row(fetch_op, 32'h0000_6020, on, pu, off, '0, 4'b0001, 32'h0023_5020);
      add_row(fill_op, 32'h0000_7000, on, ps, off, {20'h00236, 1'b0, 1'b0}, 4'b0000, 32'h0);
      add_row(fetch_op, 32'h0000_7000, on, ps, off, '0, 4'b0100, 32'h0);
      // Local memory and uncached mode.
      add_row(fill_op, 32'h0000_8000, on, ps, off, {20'h00050, 1'b0, 1'b1}, 4'b0000, 32'h0);
      add_row(fetch_op, 32'h0000_8004, on, ps, off, '0, 4'b1000, 32'h0);
      add_row(fetch_op, 32'h0000_3000, off, ps, off, '0, 4'b1000, 32'h0);
      add_row(fetch_op, 32'h0010_0100, off, ps, on, '0, 4'b1000, 32'h0);
      add_row(fetch_op, 32'h8000_0010, off, ps, off, '0, 4'b0001, 32'h8000_0010);
      add_row(fetch_op, 32'h8000_0010, off, ps, off, '0, 4'b0001, 32'h8000_0010);
      add_row(fetch_op, 32'h8000_0014, off, ps, on, '0, 4'b0001, 32'h8000_0014);
      // Fence, then the page comes back on a new frame.
      add_row(fence_op, 32'h0, on, ps, off, '0, 4'b0000, 32'h0);
      add_row(fetch_op, 32'h0000_5014, on, ps, off, '0, 4'b0010, 32'h0);
      add_row(fill_op, 32'h0000_5000, on, ps, off, {20'h00237, 1'b0, 1'b1}, 4'b0000, 32'h0);
      add_row(fetch_op, 32'h0000_5010, on, ps, off, '0, 4'b0001, 32'h0023_7010);
      add_row(fetch_op, 32'h0010_0044, off, ps, off, '0, 4'b0000, 32'h0010_0044);
   endtask

   task automatic apply_row(input row_t r, output logic done);
      int   n;
      logic accepted;
      @(negedge clk_i);
      cmd_i            = '{op: r.op, vaddr: r.vaddr, fill: r.fill};
      cmd_v_i          = 1'b1;
      translation_en_i = r.xlate;
      priv_i           = r.priv;
      uncached_mode_i  = r.ucm;
      accepted         = 1'b0;
      n                = 0;
      while (!accepted && n < cmd_timeout) begin
         @(posedge clk_i);
         accepted = cmd_yumi_o;  // Value seen by this edge.
         n++;
      end
      @(negedge clk_i);
      cmd_v_i = 1'b0;
      done    = accepted;
      if (!accepted) begin
         $display("Timeout: command for address %h was never accepted", r.vaddr);
      end else if (r.op == fetch_op) begin
         exp_resp = expected_resp(r);
         exp_v    = 1'b1;
         @(negedge clk_i);
         exp_v = 1'b0;
         n     = 0;
         while (pending != 0 && n < resp_timeout) begin
            @(negedge clk_i);
            n++;
         end
         if (pending != 0) begin
            $display("Timeout: fetch of address %h got no response", r.vaddr);
            done = 1'b0;
         end
      end
   endtask

   initial begin
      reset_i          = 1'b1;
      cmd_i            = '0;
      cmd_v_i          = 1'b0;
      translation_en_i = 1'b0;
      priv_i           = ps;
      uncached_mode_i  = 1'b0;
      exp_resp         = '0;
      exp_v            = 1'b0;
      timeouts         = 0;
      build_table();
      repeat (8) @(negedge clk_i);
      reset_i = 1'b0;
      foreach (rows[i]) begin
         if (timeouts == 0) begin
            apply_row(rows[i], ok);
            if (!ok) begin
               timeouts++;
            end
         end
      end
      $display("Fetches checked: %0d, errors: %0d, timeouts: %0d", checked, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/fe_mem_checker.sv
`timescale 1ns/100ps
`default_nettype none

module fe_mem_checker #(
   parameter int timeout_cycles = 200
) (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  fe_mem_if_pkg::fe_resp_t resp_i,
   input  logic                    resp_v_i,
   input  logic                    resp_ready_i,
   input  logic                    wb_cyc_i,
   input  fe_mem_if_pkg::fe_resp_t exp_i,
   input  logic                    exp_v_i,
   output int                      errors_o,
   output int                      checked_o,
   output int                      pending_o
);

   fe_mem_if_pkg::fe_resp_t exp_q[$];
   fe_mem_if_pkg::fe_resp_t head;
   fe_mem_if_pkg::fe_resp_t held;      // Response offered last cycle and not taken.
   logic                    held_v;
   int                      wait_cnt;
   logic                    bus_seen;  // Wishbone cycle since the fetch was queued.

   task automatic compare_resp(input fe_mem_if_pkg::fe_resp_t e, input logic bus);
      if (resp_i.data !== e.data) begin
         $display("ERR %0t: fetch %0d data %h, expected %h",
                  $time, checked_o, resp_i.data, e.data);
         errors_o++;
      end
      if ({resp_i.access_fault, resp_i.page_fault, resp_i.itlb_miss, resp_i.icache_miss}
          !== {e.access_fault, e.page_fault, e.itlb_miss, e.icache_miss}) begin
         $display("ERR %0t: fetch %0d flags %b%b%b%b, expected %b%b%b%b", $time, checked_o,
                  resp_i.access_fault, resp_i.page_fault, resp_i.itlb_miss,
                  resp_i.icache_miss, e.access_fault, e.page_fault, e.itlb_miss,
                  e.icache_miss);
         errors_o++;
      end
      // Only refills and I/O reads go out on the bus.
      if (bus !== e.icache_miss) begin
         $display("ERR %0t: fetch %0d Wishbone use %b, expected %b",
                  $time, checked_o, bus, e.icache_miss);
         errors_o++;
      end
   endtask

   always @(posedge clk_i) begin
      if (reset_i) begin
         exp_q.delete();
         errors_o  = 0;
         checked_o = 0;
         wait_cnt  = 0;
         bus_seen  = 1'b0;
         held_v    = 1'b0;
      end else begin
         if (held_v && !resp_v_i) begin
            $display("Response withdrawn at %0t before it was taken", $time);
            errors_o++;
         end else if (held_v && resp_i !== held) begin
            $display("ERR %0t: response changed from %h to %h while not taken",
                     $time, held, resp_i);
            errors_o++;
         end
         held_v = resp_v_i && !resp_ready_i;
         held   = resp_i;
         if (exp_q.size() != 0 && wb_cyc_i) begin
            bus_seen = 1'b1;
         end
         if (resp_v_i && resp_ready_i) begin
            if (exp_q.size() == 0) begin
               $display("Response taken at %0t while no fetch was outstanding", $time);
               errors_o++;
            end else begin
               head = exp_q.pop_front();
               compare_resp(head, bus_seen);
               checked_o++;
            end
            wait_cnt = 0;
            bus_seen = 1'b0;
         end else if (exp_q.size() != 0) begin
            wait_cnt++;
            if (wait_cnt > timeout_cycles) begin
               $display("Timeout: fetch %0d got no response within %0d cycles",
                        checked_o, timeout_cycles);
               errors_o++;
               head     = exp_q.pop_front();
               wait_cnt = 0;
               bus_seen = 1'b0;
            end
         end
         if (exp_v_i) begin
            exp_q.push_back(exp_i);
         end
      end
      pending_o = exp_q.size();
   end

endmodule

`default_nettype wire

// File: sim/wb_rom_model.sv
`timescale 1ns/100ps
`default_nettype none

module wb_rom_model #(
   parameter int unsigned seed_init = 0,
   parameter int          max_delay = 3
) (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  fe_mem_if_pkg::wb_req_t wb_req_i,
   output fe_mem_if_pkg::wb_rsp_t wb_rsp_o
);

   integer seed;
   int     delay;  // Wait states left before the next ack.

   initial begin
      seed     = seed_init;
      wb_rsp_o <= '0;
   end

   always @(posedge clk_i) begin
      if (reset_i) begin
         wb_rsp_o <= '0;
         delay = 0;
      end else if (wb_rsp_o.ack) begin
         wb_rsp_o.ack <= 1'b0;  // Master drops stb on the ack edge.
      end else if (wb_req_i.cyc && wb_req_i.stb) begin
         if (delay == 0) begin
            wb_rsp_o.ack <= 1'b1;
            wb_rsp_o.dat <= wb_req_i.adr ^ 32'hA5A5_0000;
            delay = $unsigned($random(seed)) % (max_delay + 1);
         end else begin
            delay--;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/fe_mem.sv
`timescale 1ns/100ps
`default_nettype none

module fe_mem (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  fe_mem_if_pkg::fe_cmd_t   cmd_i,
   input  logic                     cmd_v_i,
   output logic                     cmd_yumi_o,
   input  logic                     translation_en_i,
   input  fe_mem_geom_pkg::priv_t   priv_i,
   input  logic                     uncached_mode_i,
   output fe_mem_if_pkg::fe_resp_t  resp_o,
   output logic                     resp_v_o,
   input  logic                     resp_ready_i,
   output fe_mem_if_pkg::wb_req_t   wb_o,
   input  fe_mem_if_pkg::wb_rsp_t   wb_i
);

   fe_mem_geom_pkg::vaddr_t    lookup_vaddr;
   logic                       lookup_v;
   logic                       tlb_fill;
   logic                       tlb_fence;
   fe_mem_if_pkg::tlb_entry_t  fill_entry;
   logic                       tlb_hit;
   fe_mem_if_pkg::tlb_entry_t  tlb_entry;
   fe_mem_geom_pkg::ptag_t     ptag;
   logic                       uncached;
   logic                       access_fault;
   logic                       page_fault;
   logic                       cache_hit;
   fe_mem_geom_pkg::instr_t    cache_word;
   fe_mem_if_pkg::line_fill_t  line_fill;

   fe_mem_ctrl u_ctrl (
      .clk_i, .reset_i, .cmd_i, .cmd_v_i, .cmd_yumi_o, .translation_en_i,
      .resp_o, .resp_v_o, .resp_ready_i, .wb_o, .wb_i,
      .lookup_vaddr_o (lookup_vaddr),
      .lookup_v_o     (lookup_v),
      .tlb_fill_o     (tlb_fill),
      .tlb_fence_o    (tlb_fence),
      .fill_entry_o   (fill_entry),
      .tlb_hit_i      (tlb_hit),
      .ptag_i         (ptag),
      .uncached_i     (uncached),
      .access_fault_i (access_fault),
      .page_fault_i   (page_fault),
      .cache_hit_i    (cache_hit),
      .cache_word_i   (cache_word),
      .line_fill_o    (line_fill)
   );

   // Fills take their page number straight from the accepted command.
   fe_itlb u_itlb (
      .clk_i, .reset_i,
      .fence_i      (tlb_fence),
      .fill_i       (tlb_fill),
      .fill_vtag_i  (cmd_i.vaddr[31:12]),
      .fill_entry_i (fill_entry),
      .lookup_v_i   (lookup_v),
      .vtag_i       (lookup_vaddr[31:12]),
      .hit_o        (tlb_hit),
      .entry_o      (tlb_entry)
   );

   fe_fault_check u_fault (
      .entry_i        (tlb_entry),
      .vtag_i         (lookup_vaddr[31:12]),
      .translation_en_i,
      .priv_i,
      .uncached_mode_i,
      .ptag_o         (ptag),
      .uncached_o     (uncached),
      .access_fault_o (access_fault),
      .page_fault_o   (page_fault)
   );

   fe_icache u_icache (
      .clk_i, .reset_i,
      .lookup_v_i  (lookup_v),
      .vaddr_i     (lookup_vaddr),
      .ptag_i      (ptag),
      .hit_o       (cache_hit),
      .word_o      (cache_word),
      .line_fill_i (line_fill)
   );

endmodule

`default_nettype wire

// File: hdl/fe_mem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module fe_mem_ctrl (
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  fe_mem_if_pkg::fe_cmd_t     cmd_i,
   input  logic                       cmd_v_i,
   output logic                       cmd_yumi_o,
   input  logic                       translation_en_i,
   output fe_mem_if_pkg::fe_resp_t    resp_o,
   output logic                       resp_v_o,
   input  logic                       resp_ready_i,
   output fe_mem_if_pkg::wb_req_t     wb_o,
   input  fe_mem_if_pkg::wb_rsp_t     wb_i,
   output fe_mem_geom_pkg::vaddr_t    lookup_vaddr_o,
   output logic                       lookup_v_o,
   output logic                       tlb_fill_o,
   output logic                       tlb_fence_o,
   output fe_mem_if_pkg::tlb_entry_t  fill_entry_o,
   input  logic                       tlb_hit_i,
   input  fe_mem_geom_pkg::ptag_t     ptag_i,
   input  logic                       uncached_i,
   input  logic                       access_fault_i,
   input  logic                       page_fault_i,
   input  logic                       cache_hit_i,
   input  fe_mem_geom_pkg::instr_t    cache_word_i,
   output fe_mem_if_pkg::line_fill_t  line_fill_o
);

   fe_mem_if_pkg::ctrl_state_e state_r;
   fe_mem_geom_pkg::vaddr_t    vaddr_r;
   fe_mem_if_pkg::fe_resp_t    resp_r;
   fe_mem_geom_pkg::paddr_t    wb_adr_r;
   logic                       wb_cyc_r;
   logic                       wb_stb_r;

   logic itlb_miss, fault, go_io, go_refill, hit_path;
   logic beat_done, last_beat, want_word;

   assign cmd_yumi_o   = cmd_v_i & (state_r == fe_mem_if_pkg::st_idle);
   assign tlb_fill_o   = cmd_yumi_o & (cmd_i.op == fe_mem_if_pkg::op_fill);
   assign tlb_fence_o  = cmd_yumi_o & (cmd_i.op == fe_mem_if_pkg::op_fence);
   assign fill_entry_o = cmd_i.fill;

   assign lookup_vaddr_o = vaddr_r;
   assign lookup_v_o     = (state_r == fe_mem_if_pkg::st_lookup);
   assign resp_o         = resp_r;
   assign resp_v_o       = (state_r == fe_mem_if_pkg::st_respond);

   // ITLB miss hides any fault.
   assign itlb_miss = translation_en_i & ~tlb_hit_i;
   assign fault     = ~itlb_miss & (access_fault_i | page_fault_i);
   assign go_io     = ~itlb_miss & ~fault & uncached_i;
   assign go_refill = ~itlb_miss & ~fault & ~uncached_i & ~cache_hit_i;
   assign hit_path  = ~itlb_miss & ~fault & ~uncached_i & cache_hit_i;

   ////////////////////////////////////////////////////////////////////////////
   // Wishbone beats
   ////////////////////////////////////////////////////////////////////////////

   assign wb_o      = '{cyc: wb_cyc_r, stb: wb_stb_r, adr: wb_adr_r};
   assign beat_done = wb_stb_r & wb_i.ack;
   assign last_beat = (wb_adr_r[fe_mem_geom_pkg::word_sel_lsb +: 2]
                       == fe_mem_geom_pkg::word_sel_t'(fe_mem_geom_pkg::line_words - 1));
   assign want_word = (wb_adr_r[fe_mem_geom_pkg::word_sel_lsb +: 2]
                       == vaddr_r[fe_mem_geom_pkg::word_sel_lsb +: 2]);

   assign line_fill_o = '{v:    beat_done & (state_r == fe_mem_if_pkg::st_refill),
                          idx:  wb_adr_r[fe_mem_geom_pkg::line_idx_lsb +: 6],
                          sel:  wb_adr_r[fe_mem_geom_pkg::word_sel_lsb +: 2],
                          word: wb_i.dat,
                          last: last_beat};

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_r  <= fe_mem_if_pkg::st_idle;
         wb_cyc_r <= 1'b0;
         wb_stb_r <= 1'b0;
      end else begin
         case (state_r)
            fe_mem_if_pkg::st_idle: begin
               if (cmd_yumi_o && cmd_i.op == fe_mem_if_pkg::op_fetch) begin
                  state_r <= fe_mem_if_pkg::st_lookup;
               end
            end
            fe_mem_if_pkg::st_lookup: begin
               wb_cyc_r <= go_io | go_refill;
               wb_stb_r <= go_io | go_refill;
               if (go_io) begin
                  state_r <= fe_mem_if_pkg::st_io_read;
               end else if (go_refill) begin
                  state_r <= fe_mem_if_pkg::st_refill;
               end else begin
                  state_r <= fe_mem_if_pkg::st_respond;
               end
            end
            fe_mem_if_pkg::st_refill: begin
               if (beat_done) begin
                  wb_stb_r <= 1'b0;  // One idle cycle between beats.
                  if (last_beat) begin
                     wb_cyc_r <= 1'b0;
                     state_r  <= fe_mem_if_pkg::st_respond;
                  end
               end else if (!wb_stb_r) begin
                  wb_stb_r <= 1'b1;
               end
            end
            fe_mem_if_pkg::st_io_read: begin
               if (beat_done) begin
                  wb_cyc_r <= 1'b0;
                  wb_stb_r <= 1'b0;
                  state_r  <= fe_mem_if_pkg::st_respond;
               end
            end
            fe_mem_if_pkg::st_respond: begin
               if (resp_ready_i) begin
                  state_r <= fe_mem_if_pkg::st_idle;
               end
            end
            default: state_r <= fe_mem_if_pkg::st_idle;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Fetch address and response payload
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (cmd_yumi_o) begin
         vaddr_r <= cmd_i.vaddr;
      end
      if (state_r == fe_mem_if_pkg::st_lookup) begin
         resp_r.data         <= hit_path ? cache_word_i : '0;
         resp_r.itlb_miss    <= itlb_miss;
         resp_r.access_fault <= ~itlb_miss & access_fault_i;
         resp_r.page_fault   <= ~itlb_miss & page_fault_i;
         resp_r.icache_miss  <= go_io | go_refill;
         wb_adr_r <= uncached_i ? {ptag_i, vaddr_r[11:2], 2'b00}    // Single word.
                                : {ptag_i, vaddr_r[11:4], 4'b0000}; // Line start.
      end
      if (beat_done && state_r == fe_mem_if_pkg::st_refill) begin
         if (want_word) begin
            resp_r.data <= wb_i.dat;
         end
         wb_adr_r <= wb_adr_r + 32'd4;
      end
      if (beat_done && state_r == fe_mem_if_pkg::st_io_read) begin
         resp_r.data <= wb_i.dat;
      end
   end

   a_stb_needs_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
      wb_o.stb |-> wb_o.cyc);

   a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_o));

endmodule

`default_nettype wire

// File: hdl/fe_fault_check.sv
`timescale 1ns/100ps
`default_nettype none

module fe_fault_check (
   input  fe_mem_if_pkg::tlb_entry_t entry_i,
   input  fe_mem_geom_pkg::vtag_t    vtag_i,
   input  logic                      translation_en_i,
   input  fe_mem_geom_pkg::priv_t    priv_i,
   input  logic                      uncached_mode_i,
   output fe_mem_geom_pkg::ptag_t    ptag_o,
   output logic                      uncached_o,
   output logic                      access_fault_o,
   output logic                      page_fault_o
);

   localparam int io_bit = fe_mem_geom_pkg::uncached_bit
                         - fe_mem_geom_pkg::page_offset_width;

   logic priv_fault;
   logic exec_fault;

   assign ptag_o     = translation_en_i ? entry_i.ptag : vtag_i;
   assign uncached_o = ptag_o[io_bit];

   // Local tile memory is never fetched from.
   assign access_fault_o = (ptag_o < fe_mem_geom_pkg::dram_base_ptag)
                         | (uncached_mode_i & ~uncached_o);

   assign priv_fault = ((priv_i == fe_mem_geom_pkg::priv_s) & entry_i.u)
                     | ((priv_i == fe_mem_geom_pkg::priv_u) & ~entry_i.u);
   assign exec_fault = ~entry_i.x;

   // ITLB hit qualification is left to the controller.
   assign page_fault_o = translation_en_i & (priv_fault | exec_fault);

endmodule

`default_nettype wire

// File: hdl/fe_icache.sv
`timescale 1ns/100ps
`default_nettype none

module fe_icache (
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  logic                       lookup_v_i,
   input  fe_mem_geom_pkg::vaddr_t    vaddr_i,
   input  fe_mem_geom_pkg::ptag_t     ptag_i,
   output logic                       hit_o,
   output fe_mem_geom_pkg::instr_t    word_o,
   input  fe_mem_if_pkg::line_fill_t  line_fill_i
);

   localparam int sets  = 2 ** $bits(fe_mem_geom_pkg::line_idx_t);
   localparam int words = sets * fe_mem_geom_pkg::line_words;

   fe_mem_geom_pkg::line_tag_t tag_mem [sets];
   fe_mem_geom_pkg::instr_t    data_mem [words];
   logic [sets-1:0]            valid_r;

   fe_mem_geom_pkg::line_idx_t idx;
   fe_mem_geom_pkg::word_sel_t sel;
   fe_mem_geom_pkg::line_tag_t tag;

   ////////////////////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////////////////////

   // Index and word select sit inside the page offset.
   assign idx = vaddr_i[fe_mem_geom_pkg::line_idx_lsb +: $bits(idx)];
   assign sel = vaddr_i[fe_mem_geom_pkg::word_sel_lsb +: $bits(sel)];
   assign tag = {ptag_i,
                 vaddr_i[fe_mem_geom_pkg::page_offset_width-1:
                         fe_mem_geom_pkg::line_tag_lsb]};

   assign hit_o  = lookup_v_i & valid_r[idx] & (tag_mem[idx] == tag);
   assign word_o = data_mem[{idx, sel}];

   ////////////////////////////////////////////////////////////////////////////
   // Line fill
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r <= '0;
      end else if (line_fill_i.v) begin
         valid_r[line_fill_i.idx] <= line_fill_i.last;  // Invalid until complete.
      end
   end

   always_ff @(posedge clk_i) begin
      if (line_fill_i.v) begin
         data_mem[{line_fill_i.idx, line_fill_i.sel}] <= line_fill_i.word;
         if (line_fill_i.last) begin
            tag_mem[line_fill_i.idx] <= tag;
         end
      end
   end

   // The tag comes from the held fetch address, so both must name one line.
   a_fill_idx: assert property (@(posedge clk_i) disable iff (reset_i)
      line_fill_i.v |-> (line_fill_i.idx == idx));

endmodule

`default_nettype wire

// File: hdl/fe_itlb.sv
`timescale 1ns/100ps
`default_nettype none

module fe_itlb (
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  logic                       fence_i,
   input  logic                       fill_i,
   input  fe_mem_geom_pkg::vtag_t     fill_vtag_i,
   input  fe_mem_if_pkg::tlb_entry_t  fill_entry_i,
   input  logic                       lookup_v_i,
   input  fe_mem_geom_pkg::vtag_t     vtag_i,
   output logic                       hit_o,
   output fe_mem_if_pkg::tlb_entry_t  entry_o
);

   localparam int n = fe_mem_geom_pkg::itlb_entries;

   typedef logic [$clog2(n)-1:0] slot_t;

   logic [n-1:0]              valid_r;
   fe_mem_geom_pkg::vtag_t    vtag_r [n];
   fe_mem_if_pkg::tlb_entry_t entry_r [n];
   slot_t                     rr_r;
   slot_t                     fill_slot;
   logic [n-1:0]              hit_vec;
   logic [n-1:0]              fill_match;
   logic                      dup;

   always_comb begin
      entry_o   = '0;
      fill_slot = rr_r;
      for (int i = 0; i < n; i++) begin
         hit_vec[i]    = valid_r[i] && (vtag_r[i] == vtag_i);
         fill_match[i] = valid_r[i] && (vtag_r[i] == fill_vtag_i);
         if (hit_vec[i]) begin
            entry_o = entry_r[i];
         end
         if (fill_match[i]) begin
            fill_slot = slot_t'(i);  // Refresh an existing mapping.
         end
      end
   end

   assign hit_o = lookup_v_i & (|hit_vec);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r <= '0;
         rr_r    <= '0;
      end else if (fence_i) begin
         valid_r <= '0;
      end else if (fill_i) begin
         valid_r[fill_slot] <= 1'b1;
         if (!(|fill_match)) begin
            rr_r <= rr_r + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         vtag_r[fill_slot]  <= fill_vtag_i;
         entry_r[fill_slot] <= fill_entry_i;
      end
   end

   always_comb begin
      dup = 1'b0;
      for (int i = 0; i < n; i++) begin
         for (int j = i + 1; j < n; j++) begin
            if (valid_r[i] && valid_r[j] && (vtag_r[i] == vtag_r[j])) begin
               dup = 1'b1;
            end
         end
      end
   end

   a_no_dup_vtag: assert property (@(posedge clk_i) disable iff (reset_i) !dup);

endmodule

`default_nettype wire

// File: hdl/fe_mem_if_pkg.sv
`default_nettype none

package fe_mem_if_pkg;

   typedef enum logic [1:0] {
      op_fetch,
      op_fill,
      op_fence
   } fe_op_e;

   typedef struct packed {
      fe_mem_geom_pkg::ptag_t ptag;
      logic                   u;     // User page.
      logic                   x;     // Executable.
   } tlb_entry_t;

   typedef struct packed {
      fe_op_e                  op;
      fe_mem_geom_pkg::vaddr_t vaddr;
      tlb_entry_t              fill;
   } fe_cmd_t;

   typedef struct packed {
      fe_mem_geom_pkg::instr_t data;
      logic                    access_fault;
      logic                    page_fault;
      logic                    itlb_miss;
      logic                    icache_miss;
   } fe_resp_t;

   // Wishbone classic master side, read only.
   typedef struct packed {
      logic                    cyc;
      logic                    stb;
      fe_mem_geom_pkg::paddr_t adr;
   } wb_req_t;

   typedef struct packed {
      logic                    ack;
      fe_mem_geom_pkg::instr_t dat;
   } wb_rsp_t;

   typedef struct packed {
      logic                       v;
      fe_mem_geom_pkg::line_idx_t idx;
      fe_mem_geom_pkg::word_sel_t sel;
      fe_mem_geom_pkg::instr_t    word;
      logic                       last;
   } line_fill_t;

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_refill,
      st_io_read,
      st_respond
   } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/fe_mem_geom_pkg.sv
`default_nettype none

package fe_mem_geom_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Address and data widths
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [31:0] vaddr_t;
   typedef logic [31:0] paddr_t;
   typedef logic [19:0] vtag_t;      // Virtual page number.
   typedef logic [19:0] ptag_t;      // Physical page number.
   typedef logic [31:0] instr_t;
   typedef logic [1:0]  priv_t;

   localparam int page_offset_width = 12;

   ////////////////////////////////////////////////////////////////////////////
   // Cache and TLB geometry
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [5:0]  line_idx_t;  // 64 lines.
   typedef logic [21:0] line_tag_t;
   typedef logic [1:0]  word_sel_t;

   localparam int itlb_entries = 4;
   localparam int line_words   = 4;
   localparam int word_sel_lsb = 2;
   localparam int line_idx_lsb = 4;
   localparam int line_tag_lsb = 10;

   ////////////////////////////////////////////////////////////////////////////
   // Memory map and privilege
   ////////////////////////////////////////////////////////////////////////////

   localparam ptag_t dram_base_ptag = 20'h00100;  // Below is local memory.
   localparam int    uncached_bit   = 31;         // Set means I/O space.

   localparam priv_t priv_u = 2'b00;
   localparam priv_t priv_s = 2'b01;

endpackage

`default_nettype wire
